// ==== common/clock_pkg.sv ====
package clock_pkg;

	// ------------------------------
	// time word
	// ------------------------------
	typedef struct packed {
		logic [5:0] hr;
		logic [5:0] min;
		logic [5:0] sec;
	} hms_fields_t;

	// counting and display use fld, the alarm compare uses bits
	typedef union packed {
		hms_fields_t fld;
		logic [17:0] bits;
	} hms_t;

	localparam logic [5:0] SEC_MAX = 6'd59;
	localparam logic [5:0] MIN_MAX = 6'd59;
	localparam logic [5:0] HR_MAX  = 6'd23;

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HR  = 2'd2
	} pos_t;

	typedef logic [2:0] field_sel_t;	// one-hot, bit 0 is sec

	localparam field_sel_t FSEL_NONE = 3'b000;
	localparam field_sel_t FSEL_SEC  = 3'b001;
	localparam field_sel_t FSEL_MIN  = 3'b010;
	localparam field_sel_t FSEL_HR   = 3'b100;

	// one step up, back to 0 past the limit
	function automatic logic [5:0] hms_step(input logic [5:0] val, input logic [5:0] lim);
		return (val >= lim) ? 6'd0 : val + 6'd1;
	endfunction

	// manual set, selected fields only, no carry
	function automatic hms_t hms_step_sel(input hms_t t, input field_sel_t sel);
		hms_t r;
		r = t;
		if (sel[0])
			r.fld.sec = hms_step(t.fld.sec, SEC_MAX);
		if (sel[1])
			r.fld.min = hms_step(t.fld.min, MIN_MAX);
		if (sel[2])
			r.fld.hr = hms_step(t.fld.hr, HR_MAX);
		return r;
	endfunction

endpackage

// ==== common/disp_pkg.sv ====
package disp_pkg;

	localparam int NUM_DIGITS = 6;

	// active high, bit 6 is segment a, bit 0 is g
	typedef logic [6:0] seg_t;

	// ------------------------------
	// decimal digit patterns
	// ------------------------------
	localparam seg_t SEG_DIGIT [10] = '{
		7'b111_1110,	// 0
		7'b011_0000,	// 1
		7'b110_1101,	// 2
		7'b111_1001,	// 3
		7'b011_0011,	// 4
		7'b101_1011,	// 5
		7'b101_1111,	// 6
		7'b111_0000,	// 7
		7'b111_1111,	// 8
		7'b111_0011		// 9
	};

	localparam seg_t SEG_BLANK = 7'b000_0000;

endpackage

// ==== hw/tick_gen.sv ====
`timescale 1ns/1ps

module tick_gen #(
	parameter int unsigned SEC_DIV   = 50_000_000,
	parameter int unsigned BLINK_DIV = 12_500_000,
	parameter int unsigned SCAN_DIV  = 2500
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_sec_tick,
	output logic o_blink_tick,
	output logic o_scan_tick
);

	localparam int unsigned DIVS [3] = '{SEC_DIV, BLINK_DIV, SCAN_DIV};

	logic [31:0] cnt [3];
	logic [2:0]  tick;

	// one down-counter per tick, reload at zero
	for (genvar k = 0; k < 3; k++) begin : g_div
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt[k]  <= 32'(DIVS[k] - 1);
				tick[k] <= 1'b0;
			end else begin
				tick[k] <= (cnt[k] == 32'd0);
				if (cnt[k] == 32'd0)
					cnt[k] <= 32'(DIVS[k] - 1);
				else
					cnt[k] <= cnt[k] - 32'd1;
			end
		end
	end

	assign o_sec_tick   = tick[0];
	assign o_blink_tick = tick[1];
	assign o_scan_tick  = tick[2];

endmodule

// ==== hw/clock_ctrl.sv ====
`timescale 1ns/1ps

module clock_ctrl import clock_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_btn_mode,
	input  logic       i_btn_pos,
	input  logic       i_btn_inc,
	input  logic       i_btn_alarm,
	output mode_t      o_mode,
	output pos_t       o_pos,
	output logic       o_alarm_en,
	output logic       o_time_run,
	output field_sel_t o_time_inc,
	output field_sel_t o_alarm_inc
);

	// ------------------------------
	// button sync and edge detect
	// ------------------------------
	logic [3:0] btn_raw;
	logic [3:0] btn_s1;
	logic [3:0] btn_s2;
	logic [3:0] btn_prev;
	logic [3:0] btn_rise;

	assign btn_raw = {i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			btn_s1   <= '0;
			btn_s2   <= '0;
			btn_prev <= '0;
		end else begin
			btn_s1   <= btn_raw;
			btn_s2   <= btn_s1;
			btn_prev <= btn_s2;
		end
	end

	assign btn_rise = btn_s2 & ~btn_prev;	// one cycle per press

	// ------------------------------
	// mode, position, enable
	// ------------------------------
	field_sel_t pos_sel;

	always_comb begin
		case (o_pos)
			POS_MIN: pos_sel = FSEL_MIN;
			POS_HR:  pos_sel = FSEL_HR;
			default: pos_sel = FSEL_SEC;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode      <= MODE_CLOCK;
			o_pos       <= POS_SEC;
			o_alarm_en  <= 1'b0;
			o_time_inc  <= FSEL_NONE;
			o_alarm_inc <= FSEL_NONE;
		end else begin
			if (btn_rise[0]) begin
				case (o_mode)
					MODE_CLOCK: o_mode <= MODE_SETUP;
					MODE_SETUP: o_mode <= MODE_ALARM;
					default:    o_mode <= MODE_CLOCK;
				endcase
			end
			if (btn_rise[1]) begin
				case (o_pos)
					POS_SEC: o_pos <= POS_MIN;
					POS_MIN: o_pos <= POS_HR;
					default: o_pos <= POS_SEC;
				endcase
			end
			if (btn_rise[3])
				o_alarm_en <= ~o_alarm_en;
			// inc press goes to whichever block is being edited
			o_time_inc  <= (btn_rise[2] && o_mode == MODE_SETUP) ? pos_sel : FSEL_NONE;
			o_alarm_inc <= (btn_rise[2] && o_mode == MODE_ALARM) ? pos_sel : FSEL_NONE;
		end
	end

	assign o_time_run = (o_mode != MODE_SETUP);	// frozen while setting

endmodule

// ==== hw/time_counter.sv ====
`timescale 1ns/1ps

module time_counter import clock_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_sec_tick,
	input  logic       i_time_run,
	input  field_sel_t i_time_inc,
	output hms_t       o_time
);

	logic sec_wrap;
	logic min_wrap;

	// carry chain from the field limits
	assign sec_wrap = (o_time.fld.sec == SEC_MAX);
	assign min_wrap = sec_wrap && (o_time.fld.min == MIN_MAX);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_time.bits <= '0;
		end else if (i_time_run && i_sec_tick) begin
			o_time.fld.sec <= hms_step(o_time.fld.sec, SEC_MAX);
			if (sec_wrap)
				o_time.fld.min <= hms_step(o_time.fld.min, MIN_MAX);
			if (min_wrap)
				o_time.fld.hr <= hms_step(o_time.fld.hr, HR_MAX);
		end else if (|i_time_inc) begin
			o_time <= hms_step_sel(o_time, i_time_inc);	// manual set
		end
	end

endmodule

// ==== hw/alarm_unit.sv ====
`timescale 1ns/1ps

module alarm_unit import clock_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  hms_t       i_time,
	input  field_sel_t i_alarm_inc,
	input  logic       i_alarm_en,
	output hms_t       o_alarm_time,
	output logic       o_alarm
);

	logic match;

	// alarm time registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm_time.bits <= '0;
		else if (|i_alarm_inc)
			o_alarm_time <= hms_step_sel(o_alarm_time, i_alarm_inc);
	end

	assign match = (i_time.bits == o_alarm_time.bits);	// whole word at once

	// latched until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else
			o_alarm <= (match | o_alarm) & i_alarm_en;
	end

endmodule

// ==== display/display_scan.sv ====
`timescale 1ns/1ps

module display_scan import clock_pkg::*, disp_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  hms_t                  i_time,
	input  hms_t                  i_alarm_time,
	input  mode_t                 i_mode,
	input  pos_t                  i_pos,
	input  logic                  i_scan_tick,
	input  logic                  i_blink_tick,
	output seg_t                  o_seg,
	output logic [NUM_DIGITS-1:0] o_seg_enb
);

	localparam logic [2:0] LAST_DIGIT = 3'(NUM_DIGITS - 1);

	hms_t       src;
	logic [3:0] digit [NUM_DIGITS];
	logic [2:0] idx;
	logic       blink_off;
	logic       edit_mode;
	logic       blank;

	// ------------------------------
	// source and digit split
	// ------------------------------
	assign src = (i_mode == MODE_ALARM) ? i_alarm_time : i_time;

	always_comb begin
		digit[0] = 4'(src.fld.sec % 6'd10);
		digit[1] = 4'(src.fld.sec / 6'd10);
		digit[2] = 4'(src.fld.min % 6'd10);
		digit[3] = 4'(src.fld.min / 6'd10);
		digit[4] = 4'(src.fld.hr % 6'd10);
		digit[5] = 4'(src.fld.hr / 6'd10);
	end

	// ------------------------------
	// blink blanking
	// ------------------------------
	assign edit_mode = (i_mode == MODE_SETUP) || (i_mode == MODE_ALARM);
	// digit pair idx/2 is field sec, min, hr in pos order
	assign blank = edit_mode && blink_off && (idx[2:1] == i_pos);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx       <= 3'd0;
			blink_off <= 1'b0;
		end else begin
			if (i_scan_tick)
				idx <= (idx == LAST_DIGIT) ? 3'd0 : idx + 3'd1;
			if (i_blink_tick)
				blink_off <= ~blink_off;
		end
	end

	// ------------------------------
	// registered outputs
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg_enb <= ~NUM_DIGITS'(1);	// digit 0 on
			o_seg     <= SEG_BLANK;
		end else begin
			o_seg_enb <= ~(NUM_DIGITS'(1) << idx);
			o_seg     <= blank ? SEG_BLANK : SEG_DIGIT[digit[idx]];
		end
	end

endmodule

// ==== hw/watch_top.sv ====
`timescale 1ns/1ps

module watch_top import clock_pkg::*, disp_pkg::*; #(
	parameter int unsigned SEC_DIV   = 50_000_000,
	parameter int unsigned BLINK_DIV = 12_500_000,
	parameter int unsigned SCAN_DIV  = 2500
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_btn_mode,
	input  logic                  i_btn_pos,
	input  logic                  i_btn_inc,
	input  logic                  i_btn_alarm,
	output seg_t                  o_seg,
	output logic [NUM_DIGITS-1:0] o_seg_enb,
	output logic                  o_alarm
);

	logic       sec_tick;
	logic       blink_tick;
	logic       scan_tick;
	mode_t      mode;
	pos_t       pos;
	logic       alarm_en;
	logic       time_run;
	field_sel_t time_inc;
	field_sel_t alarm_inc;
	hms_t       cur_time;
	hms_t       alarm_time;

	tick_gen #(
		.SEC_DIV	( SEC_DIV	),
		.BLINK_DIV	( BLINK_DIV	),
		.SCAN_DIV	( SCAN_DIV	)
	) u_tick_gen (
		.clk		( clk		),
		.rst_n		( rst_n		),
		.o_sec_tick	( sec_tick	),
		.o_blink_tick	( blink_tick	),
		.o_scan_tick	( scan_tick	));

	clock_ctrl u_clock_ctrl (
		.clk		( clk		),
		.rst_n		( rst_n		),
		.i_btn_mode	( i_btn_mode	),
		.i_btn_pos	( i_btn_pos	),
		.i_btn_inc	( i_btn_inc	),
		.i_btn_alarm	( i_btn_alarm	),
		.o_mode		( mode		),
		.o_pos		( pos		),
		.o_alarm_en	( alarm_en	),
		.o_time_run	( time_run	),
		.o_time_inc	( time_inc	),
		.o_alarm_inc	( alarm_inc	));

	time_counter u_time_counter (
		.clk		( clk		),
		.rst_n		( rst_n		),
		.i_sec_tick	( sec_tick	),
		.i_time_run	( time_run	),
		.i_time_inc	( time_inc	),
		.o_time		( cur_time	));

	alarm_unit u_alarm_unit (
		.clk		( clk		),
		.rst_n		( rst_n		),
		.i_time		( cur_time	),
		.i_alarm_inc	( alarm_inc	),
		.i_alarm_en	( alarm_en	),
		.o_alarm_time	( alarm_time	),
		.o_alarm	( o_alarm	));

	display_scan u_display_scan (
		.clk		( clk		),
		.rst_n		( rst_n		),
		.i_time		( cur_time	),
		.i_alarm_time	( alarm_time	),
		.i_mode		( mode		),
		.i_pos		( pos		),
		.i_scan_tick	( scan_tick	),
		.i_blink_tick	( blink_tick	),
		.o_seg		( o_seg		),
		.o_seg_enb	( o_seg_enb	));

endmodule

// ==== tb/watch_assertions.sv ====
`timescale 1ns/1ps

module watch_assertions import clock_pkg::*; (
	input logic       clk,
	input logic       rst_n,
	input logic [5:0] i_seg_enb,
	input logic       i_alarm,
	input logic       i_alarm_en,
	input hms_t       i_time,
	input hms_t       i_alarm_time
);

	a_enb_one_cold: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~i_seg_enb))
		else $error("digit enables not one-cold: %b", i_seg_enb);

	// alarm needs the enable and either a time match or its own latch
	a_alarm_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
		i_alarm |-> $past(i_alarm_en) &&
			($past(i_alarm) || $past(i_time.fld == i_alarm_time.fld)))
		else $error("alarm high without enable or time match");

	a_field_limits: assert property (@(posedge clk) disable iff (!rst_n)
		i_time.fld.sec <= SEC_MAX && i_time.fld.min <= MIN_MAX && i_time.fld.hr <= HR_MAX)
		else $error("time field out of range: %h", i_time.bits);

endmodule

bind watch_top watch_assertions u_watch_assertions (
	.clk		( clk		),
	.rst_n		( rst_n		),
	.i_seg_enb	( o_seg_enb	),
	.i_alarm	( o_alarm	),
	.i_alarm_en	( alarm_en	),
	.i_time		( cur_time	),
	.i_alarm_time	( alarm_time	));

// ==== tb/tb_watch.sv ====
`timescale 1ns/1ps

module tb_watch import disp_pkg::*; ();

	localparam int unsigned SEC_DIV   = 2000;
	localparam int unsigned BLINK_DIV = 400;
	localparam int unsigned SCAN_DIV  = 8;
	localparam int DIGIT_TIMEOUT = 2000;	// cycles, well past one blink phase

	logic                  clk;
	logic                  rst_n;
	logic                  i_btn_mode;
	logic                  i_btn_pos;
	logic                  i_btn_inc;
	logic                  i_btn_alarm;
	seg_t                  o_seg;
	logic [NUM_DIGITS-1:0] o_seg_enb;
	logic                  o_alarm;

	int checks;
	int errors;
	int timeouts;

	watch_top #(
		.SEC_DIV	( SEC_DIV	),
		.BLINK_DIV	( BLINK_DIV	),
		.SCAN_DIV	( SCAN_DIV	)
	) u_watch_top (
		.clk		( clk		),
		.rst_n		( rst_n		),
		.i_btn_mode	( i_btn_mode	),
		.i_btn_pos	( i_btn_pos	),
		.i_btn_inc	( i_btn_inc	),
		.i_btn_alarm	( i_btn_alarm	),
		.o_seg		( o_seg		),
		.o_seg_enb	( o_seg_enb	),
		.o_alarm	( o_alarm	));

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ------------------------------
	// stimulus tasks
	// ------------------------------
	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic drive_button(input int btn, input logic level);
		case (btn)
			0:       i_btn_mode  = level;
			1:       i_btn_pos   = level;
			2:       i_btn_inc   = level;
			default: i_btn_alarm = level;
		endcase
	endtask

	task automatic press_button(input int btn, input int count);
		repeat (count) begin
			drive_button(btn, 1'b1);
			repeat (6) @(negedge clk);
			drive_button(btn, 1'b0);
			repeat (6) @(negedge clk);
		end
	endtask

	// ------------------------------
	// display reading and checks
	// ------------------------------
	// val holds one decimal digit per nibble, digit 0 in the low nibble
	task automatic read_display(output logic [23:0] val, output logic ok);
		int   i;
		int   k;
		int   cycles;
		logic found;
		logic known;
		val = '0;
		ok  = 1'b1;
		for (i = 0; i < NUM_DIGITS; i++) begin
			cycles = 0;
			found  = 1'b0;
			while (!found && cycles < DIGIT_TIMEOUT) begin
				@(negedge clk);
				cycles++;
				found = (o_seg_enb == ~(NUM_DIGITS'(1) << i)) && (o_seg != SEG_BLANK);
			end
			if (!found) begin
				$display("Timeout at %0t: digit %0d was never shown lit", $time, i);
				timeouts++;
				ok = 1'b0;
			end else begin
				known = 1'b0;
				for (k = 0; k < 10; k++) begin
					if (o_seg == SEG_DIGIT[k]) begin
						val[4*i +: 4] = 4'(k);
						known = 1'b1;
					end
				end
				if (!known) begin
					$display("Fail at %0t: digit %0d shows pattern %b", $time, i, o_seg);
					errors++;
					ok = 1'b0;
				end
			end
		end
	endtask

	task automatic check_display(input logic [23:0] exp, input logic [23:0] alt);
		logic [23:0] got;
		logic        ok;
		read_display(got, ok);
		checks++;
		if (ok && got != exp && got != alt) begin
			errors++;
			$display("Fail at %0t: display reads %h, expected %h or %h", $time, got, exp, alt);
		end
	endtask

	task automatic check_alarm(input logic level);
		checks++;
		if (o_alarm !== level) begin
			errors++;
			$display("Fail at %0t: alarm is %b, expected %b", $time, o_alarm, level);
		end
	endtask

	// ------------------------------
	// command file
	// ------------------------------
	initial begin
		integer        fd;
		int            n;
		int            arg_a;
		int            arg_b;
		logic          done;
		logic [7:0]    cmd;
		logic [1023:0] line_buf;
		logic [23:0]   exp_digits;
		logic [23:0]   alt_digits;
		rst_n       = 1'b0;
		i_btn_mode  = 1'b0;
		i_btn_pos   = 1'b0;
		i_btn_inc   = 1'b0;
		i_btn_alarm = 1'b0;
		checks      = 0;
		errors      = 0;
		timeouts    = 0;
		apply_reset();
		fd = $fopen("tb/watch_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open the data file tb/watch_testdata.txt");
			errors++;
		end else begin
			done = 1'b0;
			while (!done) begin
				n = $fscanf(fd, "%s", cmd);
				if (n != 1) begin
					done = 1'b1;
				end else if (cmd == "#") begin
					n = $fgets(line_buf, fd);	// rest of a comment line
				end else if (cmd == "p") begin
					n = $fscanf(fd, "%d %d", arg_a, arg_b);
					press_button(arg_a, arg_b);
				end else if (cmd == "w") begin
					n = $fscanf(fd, "%d", arg_a);
					repeat (arg_a * SEC_DIV + SEC_DIV / 2) @(negedge clk);
				end else if (cmd == "d") begin
					n = $fscanf(fd, "%h %h", exp_digits, alt_digits);
					check_display(exp_digits, alt_digits);
				end else if (cmd == "a") begin
					n = $fscanf(fd, "%d", arg_a);
					check_alarm(arg_a[0]);
				end else if (cmd == "r") begin
					apply_reset();
				end else begin
					$display("Unknown command %s in the data file", cmd);
					errors++;
					done = 1'b1;
				end
			end
			$fclose(fd);
		end
		$display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks > 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== tb/watch_testdata.txt ====
# commands: p btn count (btn 0 mode, 1 pos, 2 inc, 3 alarm) | w seconds | r reset
# d digits alt (hhmmss, one hex nibble per digit) | a alarm level
# reset state
d 000000 000000 a 0
# setup mode, each field steps with a wrap and no carry
p 0 1 p 2 3 d 000003 000003
p 1 1 p 2 5 d 000503 000503 p 2 55 d 000003 000003
p 1 1 p 2 24 d 000003 000003 w 2 d 000003 000003
# set 23:59:57, run about 4 s, freeze again
p 2 23 p 1 1 p 2 54 p 1 1 p 2 59 d 235957 235957
p 0 2 w 4 p 0 1 d 000001 000002
# alarm mode shows and sets the alarm time while the time runs
r p 0 2 p 2 2 p 1 1 p 2 5 p 1 1 p 2 2 d 020502 020502
w 2 p 0 2 d 000002 000003
# alarm at 00:00:03 with the enable off
r p 0 2 p 2 3 p 0 1 a 0 w 5 a 0
# alarm moved to 00:00:08 and enabled, then disabled
p 0 2 p 2 5 p 0 1 p 3 1 a 0 w 5 a 1 p 3 1 a 0

// ==== compile.f ====
common/clock_pkg.sv
common/disp_pkg.sv
hw/tick_gen.sv
hw/clock_ctrl.sv
hw/time_counter.sv
hw/alarm_unit.sv
display/display_scan.sv
hw/watch_top.sv
tb/watch_assertions.sv
tb/tb_watch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -euo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_watch -f compile.f -o sim_watch
./obj_dir/sim_watch | tee sim.log

if grep -q "Checks failed" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
echo "simulation finished without failures"
